// ==== build.f ====
common/na_pkg.sv
hdl/bus_arbiter.sv
na_conf/na_conf.sv
na_mp/na_mp_buffer.sv
hdl/na_top.sv
tests/na_chk.sv
tests/tb_na.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_na -Mdir obj_dir -f build.f

# Assertion errors must not stop the run, so the closing result is always printed
./obj_dir/Vtb_na +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== tests/tb_na.sv ====
// ========================================
// Testbench of the adapter front end:
// clock, reset, bus transfers from both
// masters, per-test checks and the result
// ========================================

module tb_na;

  timeunit 1ns;
  timeprecision 1ps;

  import na_pkg::*;

  // Longest wait for ready, in cycles
  localparam int MAX_WAIT = 8;

  logic     clk;
  logic     rst;
  bus_req_t core_req;
  bus_req_t dbg_req;
  bus_rsp_t core_rsp;
  bus_rsp_t dbg_rsp;

  int   errors = 0;
  int   failed_tests = 0;
  int   cycle = 0;
  logic favor_m1 = 1'b0;

  na_top i_na_top (
    .clk      (clk),
    .rst      (rst),
    .core_req (core_req),
    .dbg_req  (dbg_req),
    .core_rsp (core_rsp),
    .dbg_rsp  (dbg_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle stamp that orders completions of the two masters
  always @(posedge clk) cycle <= cycle + 1;

  // ========================================
  // Reference values from the register map
  // ========================================

  function automatic logic [31:0] conf_value(input logic [11:0] off);
    case (off)
      REG_TILEID:          return TILE_ID;
      REG_NUMTILES:        return NUM_TILES;
      REG_CONF:            return {30'h0, DMA_ENABLE, MP_ENABLE};
      REG_COREBASE:        return CORE_BASE;
      REG_DOMAIN_NUMCORES: return CORES_PER_TILE;
      REG_GMEM_SIZE:       return GMEM_SIZE;
      REG_GMEM_TILE:       return GMEM_TILE;
      REG_LMEM_SIZE:       return LMEM_SIZE;
      REG_NUMCTS:          return NUM_CTS;
      default:             return 32'h0;
    endcase
  endfunction

  // Entry idx counts from the end of CT_LIST, entries past NUM_CTS are zero
  function automatic logic [31:0] ctlist_value(input int idx, input logic half);
    logic [15:0] id;
    id = 16'h0000;
    if (idx < int'(NUM_CTS)) begin
      id = CT_LIST[int'(NUM_CTS) - 1 - idx];
    end
    return half ? {16'h0000, id} : {id, 16'h0000};
  endfunction

  // ========================================
  // Bus transfer and checks
  // ========================================

  // Drives one request on a falling edge and holds it until ready is seen mid cycle
  task automatic access(input logic m1, input logic wr, input logic [15:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic resp, output int done_cycle);
    bus_req_t r;
    bus_rsp_t s;
    int       waited;
    r       = '0;
    r.sel   = 1'b1;
    r.write = wr;
    r.addr  = addr;
    r.wdata = wdata;
    waited  = 0;
    @(negedge clk);
    if (m1) begin
      dbg_req = r;
    end else begin
      core_req = r;
    end
    #5;
    s = m1 ? dbg_rsp : core_rsp;
    while (!s.ready && waited < MAX_WAIT) begin
      @(negedge clk);
      #5;
      s = m1 ? dbg_rsp : core_rsp;
      waited++;
    end
    if (!s.ready) begin
      $display("Master %0d saw no ready for address %h within %0d cycles at time %0t",
               m1, addr, MAX_WAIT, $time);
      $display("Test failed");
      $finish;
    end else begin
      rdata      = s.rdata;
      resp       = s.resp;
      done_cycle = cycle;
      // The pointer favors the other master after each completion
      favor_m1   = ~m1;
      @(negedge clk);
      if (m1) begin
        dbg_req = '0;
      end else begin
        core_req = '0;
      end
    end
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp, input logic got_resp,
                           input logic exp_resp);
    assert (got === exp && got_resp === exp_resp) else begin
      $display("Error at %0t: %s gave %h resp %b, expected %h resp %b",
               $time, what, got, got_resp, exp, exp_resp);
      errors++;
    end
  endtask

  // Writes and refused accesses define no read data, so only resp is compared
  task automatic check_resp(input string what, input logic got_resp,
                            input logic exp_resp);
    assert (got_resp === exp_resp) else begin
      $display("Error at %0t: %s gave resp %b, expected resp %b",
               $time, what, got_resp, exp_resp);
      errors++;
    end
  endtask

  task automatic report(input string name, input int mark);
    if (errors == mark) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, errors - mark);
      failed_tests++;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [31:0] rd;
    logic [31:0] rd1;
    logic        rs;
    logic        rs1;
    int          dc0;
    int          dc1;
    int          mark;
    int          idx;
    logic        m1_first;
    logic [31:0] words [MP_DEPTH];
    logic [11:0] offs [9];
    void'($urandom(32'h55d3_0723));
    core_req = '0;
    dbg_req  = '0;
    rst      = 1'b1;
    offs = '{REG_TILEID, REG_NUMTILES, REG_CONF, REG_COREBASE, REG_DOMAIN_NUMCORES,
             REG_GMEM_SIZE, REG_GMEM_TILE, REG_LMEM_SIZE, REG_NUMCTS};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    mark = errors;
    foreach (offs[i]) begin
      access(1'b0, 1'b0, {PAGE_CONF, offs[i]}, '0, rd, rs, dc0);
      expect_eq($sformatf("conf 0x%03h", offs[i]), rd, conf_value(offs[i]), rs, 1'b0);
    end
    report("configuration reads", mark);

    // Both halves of every entry, masters taking turns
    mark = errors;
    for (int i = 0; i < 64; i++) begin
      for (int h = 0; h < 2; h++) begin
        access(i[0], 1'b0, {PAGE_CONF, CTLIST_BASE + 12'(i * 8 + h * 4)}, '0, rd, rs, dc0);
        expect_eq($sformatf("ctlist %0d half %0d", i, h), rd, ctlist_value(i, h[0]), rs, 1'b0);
      end
    end
    report("compute tile list", mark);

    mark = errors;
    for (int i = 0; i < MP_DEPTH; i++) begin
      words[i] = $urandom;
      access(1'b0, 1'b1, {PAGE_MP, MP_DATA}, words[i], rd, rs, dc0);
      check_resp("push", rs, 1'b0);
      access(1'b1, 1'b0, {PAGE_MP, MP_FILL}, '0, rd, rs, dc0);
      expect_eq("fill after push", rd, 32'(i + 1), rs, 1'b0);
    end
    for (int i = 0; i < MP_DEPTH; i++) begin
      access(1'b0, 1'b0, {PAGE_MP, MP_DATA}, '0, rd, rs, dc0);
      expect_eq($sformatf("pop %0d", i), rd, words[i], rs, 1'b0);
      access(1'b1, 1'b0, {PAGE_MP, MP_FILL}, '0, rd, rs, dc0);
      expect_eq("fill after pop", rd, 32'(MP_DEPTH - 1 - i), rs, 1'b0);
    end
    report("message buffer order and fill", mark);

    mark = errors;
    access(1'b0, 1'b1, {PAGE_CONF, REG_TILEID}, $urandom, rd, rs, dc0);
    check_resp("conf write", rs, 1'b1);
    access(1'b1, 1'b0, {PAGE_CONF, 12'h008}, '0, rd, rs, dc0);
    check_resp("conf hole", rs, 1'b1);
    access(1'b0, 1'b0, {PAGE_MP, MP_DATA}, '0, rd, rs, dc0);
    expect_eq("pop on empty", rd, 32'h0, rs, 1'b1);
    access(1'b0, 1'b0, {4'h5, 12'h000}, '0, rd, rs, dc0);
    expect_eq("unmapped page", rd, 32'h0, rs, 1'b1);
    for (int i = 0; i < MP_DEPTH; i++) begin
      words[i] = $urandom;
      access(1'b1, 1'b1, {PAGE_MP, MP_DATA}, words[i], rd, rs, dc0);
    end
    access(1'b0, 1'b1, {PAGE_MP, MP_DATA}, $urandom, rd, rs, dc0);
    check_resp("push on full", rs, 1'b1);
    access(1'b1, 1'b1, {PAGE_MP, MP_FILL}, 32'h0, rd, rs, dc0);
    check_resp("fill write", rs, 1'b1);
    access(1'b0, 1'b0, {PAGE_MP, MP_FILL}, '0, rd, rs, dc0);
    expect_eq("fill after errors", rd, 32'(MP_DEPTH), rs, 1'b0);
    // The refused push must not show up among the drained words
    for (int i = 0; i < MP_DEPTH; i++) begin
      access(1'b0, 1'b0, {PAGE_MP, MP_DATA}, '0, rd, rs, dc0);
      expect_eq("drain after errors", rd, words[i], rs, 1'b0);
    end
    report("error responses", mark);

    // Odd rounds first move the pointer with a single transfer of the favored master
    mark = errors;
    for (int r = 0; r < 8; r++) begin
      if (r[0]) begin
        access(favor_m1, 1'b0, {PAGE_CONF, REG_TILEID}, '0, rd, rs, dc0);
      end
      m1_first = favor_m1;
      idx      = $urandom_range(63, 0);
      fork
        access(1'b0, 1'b0, {PAGE_CONF, offs[r % 9]}, '0, rd, rs, dc0);
        access(1'b1, 1'b0, {PAGE_CONF, CTLIST_BASE + 12'(idx * 8 + 4)}, '0, rd1, rs1, dc1);
      join
      expect_eq("arbitrated core read", rd, conf_value(offs[r % 9]), rs, 1'b0);
      expect_eq("arbitrated debug read", rd1, ctlist_value(idx, 1'b1), rs1, 1'b0);
      assert (m1_first ? (dc0 == dc1 + 1) : (dc1 == dc0 + 1)) else begin
        $display("Error at %0t: grant order core cycle %0d debug cycle %0d, debug first %b",
                 $time, dc0, dc1, m1_first);
        errors++;
      end
    end
    report("arbitration", mark);

    // Leave words in the buffer, then reset in the middle of the run
    mark = errors;
    for (int i = 0; i < 3; i++) begin
      access(1'b0, 1'b1, {PAGE_MP, MP_DATA}, $urandom, rd, rs, dc0);
    end
    @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst      = 1'b0;
    favor_m1 = 1'b0;
    repeat (3) begin
      @(negedge clk);
      #5;
      assert (!core_rsp.ready && !core_rsp.resp && !dbg_rsp.ready && !dbg_rsp.resp) else begin
        $display("Error at %0t: response active without a request after reset", $time);
        errors++;
      end
    end
    access(1'b1, 1'b0, {PAGE_MP, MP_FILL}, '0, rd, rs, dc0);
    expect_eq("fill after reset", rd, 32'h0, rs, 1'b0);
    report("reset", mark);

    $display("Tests run: 6, with errors: %0d, check errors: %0d, assertion failures: %0d",
             failed_tests, errors, i_na_top.i_chk.fails);
    if (errors == 0 && i_na_top.i_chk.fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tests/na_chk.sv ====
// ========================================
// Concurrent bus protocol checks of the
// adapter top level, attached by bind
// ========================================

module na_chk (
  input logic                      clk,
  input logic                      rst,
  input na_pkg::bus_req_t          core_req,
  input na_pkg::bus_req_t          dbg_req,
  input na_pkg::bus_rsp_t          core_rsp,
  input na_pkg::bus_rsp_t          dbg_rsp,
  input logic [na_pkg::MP_PTR_W:0] fill
);

  timeunit 1ns;
  timeprecision 1ps;

  import na_pkg::*;

  // Count of failed assertions, summed into the closing result
  int unsigned fails = 0;

  logic core_wait;
  logic dbg_wait;

  // A master waits while its sel is up and no ready comes back
  assign core_wait = core_req.sel & ~core_rsp.ready;
  assign dbg_wait  = dbg_req.sel & ~dbg_rsp.ready;

  // Only the granted master sees ready
  one_ready: assert property (@(posedge clk) disable iff (rst)
    !(core_rsp.ready && dbg_rsp.ready))
    else begin
      $error("both masters see ready in one cycle");
      fails++;
    end

  // Ready only answers a request of the same master
  ready_needs_sel: assert property (@(posedge clk) disable iff (rst)
    (!core_rsp.ready || core_req.sel) && (!dbg_rsp.ready || dbg_req.sel))
    else begin
      $error("ready seen without a matching sel");
      fails++;
    end

  // The loser is served in the next cycle, so three waiting cycles are too many
  no_starve: assert property (@(posedge clk) disable iff (rst)
    !(core_wait && $past(core_wait) && $past(core_wait, 2)) &&
    !(dbg_wait && $past(dbg_wait) && $past(dbg_wait, 2)))
    else begin
      $error("held request not served within 2 cycles");
      fails++;
    end

  fill_bound: assert property (@(posedge clk) disable iff (rst)
    int'(fill) <= MP_DEPTH)
    else begin
      $error("message buffer fill above its depth");
      fails++;
    end

endmodule

bind na_top na_chk i_chk (
  .clk      (clk),
  .rst      (rst),
  .core_req (core_req),
  .dbg_req  (dbg_req),
  .core_rsp (core_rsp),
  .dbg_rsp  (dbg_rsp),
  .fill     (i_mp.fill)
);

// ==== hdl/na_top.sv ====
// ========================================
// Network adapter register front end: the
// master arbiter, the page decoder with its
// response mux, and the two register peers
// ========================================

module na_top (
  input  logic             clk,
  input  logic             rst,
  input  na_pkg::bus_req_t core_req,
  input  na_pkg::bus_req_t dbg_req,
  output na_pkg::bus_rsp_t core_rsp,
  output na_pkg::bus_rsp_t dbg_rsp
);

  import na_pkg::*;

  // Shared bus behind the arbiter
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  // Per peer request and response
  bus_req_t conf_req;
  bus_rsp_t conf_rsp;
  bus_req_t mp_req;
  bus_rsp_t mp_rsp;

  logic [3:0] page;

  // Core data port is master 0, debug port is master 1
  bus_arbiter i_arb (
    .clk     (clk),
    .rst     (rst),
    .m0_req  (core_req),
    .m1_req  (dbg_req),
    .m0_rsp  (core_rsp),
    .m1_rsp  (dbg_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  // ========================================
  // Page decoder
  // ========================================

  assign page = bus_req.addr.regs.page;

  // A peer only sees sel while its own page is addressed
  always_comb begin
    conf_req     = bus_req;
    mp_req       = bus_req;
    conf_req.sel = bus_req.sel & (page == PAGE_CONF);
    mp_req.sel   = bus_req.sel & (page == PAGE_MP);
  end

  na_conf i_conf (
    .req (conf_req),
    .rsp (conf_rsp)
  );

  na_mp_buffer i_mp (
    .clk (clk),
    .rst (rst),
    .req (mp_req),
    .rsp (mp_rsp)
  );

  // Unmapped pages are answered here with an immediate error
  always_comb begin
    case (page)
      PAGE_CONF: bus_rsp = conf_rsp;
      PAGE_MP:   bus_rsp = mp_rsp;
      default: begin
        bus_rsp.rdata = 32'h0000_0000;
        bus_rsp.ready = bus_req.sel;
        bus_rsp.resp  = bus_req.sel;
      end
    endcase
  end

endmodule

// ==== na_mp/na_mp_buffer.sv ====
// ========================================
// Simple message buffer: a word FIFO that
// software pushes through MP_DATA, pops
// through MP_DATA and watches through MP_FILL
// ========================================

module na_mp_buffer (
  input  logic             clk,
  input  logic             rst,
  input  na_pkg::bus_req_t req,
  output na_pkg::bus_rsp_t rsp
);

  import na_pkg::*;

  localparam logic [MP_PTR_W:0] FILL_MAX = (MP_PTR_W + 1)'(MP_DEPTH);

  logic [31:0]         mem [MP_DEPTH];
  logic [MP_PTR_W-1:0] wr_ptr;
  logic [MP_PTR_W-1:0] rd_ptr;
  logic [MP_PTR_W:0]   fill;

  logic is_data;
  logic is_fill;
  logic push_req;
  logic pop_req;
  logic full;
  logic empty;
  logic push;
  logic pop;

  // ========================================
  // Access decode
  // ========================================

  assign is_data = (req.addr.regs.word == MP_DATA[11:2]);
  assign is_fill = (req.addr.regs.word == MP_FILL[11:2]);

  // The buffer is always ready, so sel alone marks the completion cycle
  assign push_req = req.sel & req.write & is_data;
  assign pop_req  = req.sel & ~req.write & is_data;

  assign full  = (fill == FILL_MAX);
  assign empty = (fill == '0);

  // Refused accesses leave pointers and fill alone
  assign push = push_req & ~full;
  assign pop  = pop_req & ~empty;

  // ========================================
  // Storage and pointers
  // ========================================

  // Storage holds payload only and starts undefined
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= req.wdata;
    end
  end

  // Pointers wrap by themselves since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
        fill   <= fill + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        fill   <= fill - 1'b1;
      end
    end
  end

  // ========================================
  // Response
  // ========================================

  // A pop on an empty buffer returns zero
  always_comb begin
    rsp.rdata = 32'h0000_0000;
    if (pop) begin
      rsp.rdata = mem[rd_ptr];
    end else if (is_fill && !req.write) begin
      rsp.rdata = 32'(fill);
    end
  end

  assign rsp.ready = req.sel;

  // Full push, empty pop, fill writes and unknown offsets are errors
  assign rsp.resp = (push_req & full) | (pop_req & empty) |
                    (req.sel & req.write & is_fill) |
                    (req.sel & ~is_data & ~is_fill);

endmodule

// ==== na_conf/na_conf.sv ====
// ========================================
// Read-only configuration registers of the
// network adapter and the compute tile list,
// answered combinationally
// ========================================

// Configuration page layout
//   0x000 tile id
//   0x004 number of tiles
//   0x00c feature flags, bit 0 message buffer, bit 1 DMA
//   0x010 first core id of the tile
//   0x018 cores in the domain
//   0x01c global memory size
//   0x020 global memory tile
//   0x024 local memory size
//   0x028 number of compute tiles
//   0x200 compute tile list, 8 bytes per entry

module na_conf (
  input  na_pkg::bus_req_t req,
  output na_pkg::bus_rsp_t rsp
);

  import na_pkg::*;

  // List ordered by index as software expects it, reversed against CT_LIST
  logic [15:0] ctlist_rev [64];
  logic        in_ctlist;
  logic        hit;
  logic [31:0] rdata;

  // ========================================
  // Reversed compute tile list
  // ========================================

  for (genvar i = 0; i < 64; i++) begin : gen_ctlist
    if (i < NUM_CTS) begin : gen_valid
      assign ctlist_rev[i] = CT_LIST[NUM_CTS - 1 - i];
    end else begin : gen_unused
      // Slots past the last compute tile read as zero
      assign ctlist_rev[i] = 16'h0000;
    end
  end

  // The list region covers 0x200 to 0x3ff of the page
  assign in_ctlist = (req.addr.ctlist.region == CTLIST_BASE[11:9]);

  // ========================================
  // Read decode
  // ========================================

  always_comb begin
    rdata = 32'h0000_0000;
    hit   = 1'b1;
    if (in_ctlist) begin
      // Half select 1 returns the id in the low half of the word
      if (req.addr.ctlist.half) begin
        rdata = {16'h0000, ctlist_rev[req.addr.ctlist.entry]};
      end else begin
        rdata = {ctlist_rev[req.addr.ctlist.entry], 16'h0000};
      end
    end else begin
      case (req.addr.regs.word)
        REG_TILEID[11:2]: begin
          rdata = TILE_ID;
        end
        REG_NUMTILES[11:2]: begin
          rdata = NUM_TILES;
        end
        REG_CONF[11:2]: begin
          rdata = {30'h0, DMA_ENABLE, MP_ENABLE};
        end
        REG_COREBASE[11:2]: begin
          rdata = CORE_BASE;
        end
        REG_DOMAIN_NUMCORES[11:2]: begin
          rdata = CORES_PER_TILE;
        end
        REG_GMEM_SIZE[11:2]: begin
          rdata = GMEM_SIZE;
        end
        REG_GMEM_TILE[11:2]: begin
          rdata = GMEM_TILE;
        end
        REG_LMEM_SIZE[11:2]: begin
          rdata = LMEM_SIZE;
        end
        REG_NUMCTS[11:2]: begin
          rdata = NUM_CTS;
        end
        default: begin
          // Holes such as 0x008 and 0x014 belong to no register
          hit = 1'b0;
        end
      endcase
    end
  end

  // ========================================
  // Response
  // ========================================

  // Always ready, writes and unmatched words are flagged
  assign rsp.rdata = rdata;
  assign rsp.ready = req.sel;
  assign rsp.resp  = req.sel & (req.write | ~hit);

endmodule

// ==== hdl/bus_arbiter.sv ====
// ========================================
// Round-robin arbiter that puts one of two
// register bus masters onto the shared bus,
// with a one-bit priority pointer
// ========================================

module bus_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  na_pkg::bus_req_t m0_req,
  input  na_pkg::bus_req_t m1_req,
  output na_pkg::bus_rsp_t m0_rsp,
  output na_pkg::bus_rsp_t m1_rsp,
  output na_pkg::bus_req_t bus_req,
  input  na_pkg::bus_rsp_t bus_rsp
);

  import na_pkg::*;

  // Pointer low favors master 0, high favors master 1
  logic prio;
  logic grant_m1;
  logic done;

  // Master 1 wins when it is alone or when the pointer favors it
  assign grant_m1 = m1_req.sel & (~m0_req.sel | prio);

  // With no request at all the idle master 0 request passes with sel low
  assign bus_req = grant_m1 ? m1_req : m0_req;

  // A transfer ends in the cycle that sel and ready are both high
  assign done = bus_req.sel & bus_rsp.ready;

  // The loser sees ready low and keeps holding its request
  always_comb begin
    m0_rsp = '0;
    m1_rsp = '0;
    if (grant_m1) begin
      m1_rsp = bus_rsp;
    end else begin
      m0_rsp = bus_rsp;
    end
  end

  // ========================================
  // Priority pointer
  // ========================================

  // After every completed transfer the other master is favored
  always_ff @(posedge clk) begin
    if (rst) begin
      prio <= 1'b0;
    end else if (done) begin
      prio <= ~grant_m1;
    end
  end

endmodule

// ==== common/na_pkg.sv ====
// ========================================
// Shared definitions of the network adapter
// register front end: tile configuration
// constants, buffer sizing, register offsets,
// the address union and the bus structs
// ========================================

package na_pkg;

  // ========================================
  // Tile configuration
  // ========================================

  localparam logic [31:0] TILE_ID        = 32'd3;
  localparam logic [31:0] NUM_TILES      = 32'd16;
  localparam logic [31:0] CORE_BASE      = 32'd12;
  localparam logic [31:0] CORES_PER_TILE = 32'd4;
  localparam logic [31:0] GMEM_SIZE      = 32'h0100_0000;
  localparam logic [31:0] GMEM_TILE      = 32'd15;
  localparam logic [31:0] LMEM_SIZE      = 32'h0001_0000;

  // Number of compute tiles, at most 64
  localparam logic [31:0] NUM_CTS = 32'd5;

  // Compute tile ids, only the first NUM_CTS entries carry meaning
  localparam logic [15:0] CT_LIST [64] = '{
    0: 16'h0002,
    1: 16'h0003,
    2: 16'h0005,
    3: 16'h0006,
    4: 16'h0009,
    default: 16'h0000
  };

  // Feature flags reported in REG_CONF
  localparam logic MP_ENABLE  = 1'b1;
  localparam logic DMA_ENABLE = 1'b0;

  // Message buffer depth in words, a power of two
  localparam int MP_DEPTH = 8;
  localparam int MP_PTR_W = $clog2(MP_DEPTH);

  // ========================================
  // Register map
  // ========================================

  // Byte offsets inside the configuration page
  localparam logic [11:0] REG_TILEID          = 12'h000;
  localparam logic [11:0] REG_NUMTILES        = 12'h004;
  localparam logic [11:0] REG_CONF            = 12'h00c;
  localparam logic [11:0] REG_COREBASE        = 12'h010;
  localparam logic [11:0] REG_DOMAIN_NUMCORES = 12'h018;
  localparam logic [11:0] REG_GMEM_SIZE       = 12'h01c;
  localparam logic [11:0] REG_GMEM_TILE       = 12'h020;
  localparam logic [11:0] REG_LMEM_SIZE       = 12'h024;
  localparam logic [11:0] REG_NUMCTS          = 12'h028;
  localparam logic [11:0] CTLIST_BASE         = 12'h200;

  // Byte offsets inside the message page
  localparam logic [11:0] MP_DATA = 12'h000;
  localparam logic [11:0] MP_FILL = 12'h004;

  // Pages selected by the top four address bits
  localparam logic [3:0] PAGE_CONF = 4'd0;
  localparam logic [3:0] PAGE_MP   = 4'd1;

  // ========================================
  // Address and bus types
  // ========================================

  // Plain register view of an address
  typedef struct packed {
    logic [3:0] page;
    logic [9:0] word;
    logic [1:0] byte_off;
  } na_reg_addr_t;

  // Compute tile list view, two 16 bit halves per 8 byte entry
  typedef struct packed {
    logic [3:0] page;
    logic [2:0] region;
    logic [5:0] entry;
    logic       half;
    logic [1:0] low;
  } na_ctlist_addr_t;

  typedef union packed {
    na_reg_addr_t    regs;
    na_ctlist_addr_t ctlist;
  } na_addr_u;

  typedef struct packed {
    logic        sel;
    logic        write;
    na_addr_u    addr;
    logic [31:0] wdata;
  } bus_req_t;

  // A resp of 1 marks an error
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
    logic        resp;
  } bus_rsp_t;

endpackage
